// File: project.f
+incdir+test
rtl/deskew_cfg_pkg.sv
rtl/deskew_ctrl_pkg.sv
rtl/skew_counter.sv
rtl/deskew_fsm.sv
rtl/lane_delay_line.sv
rtl/deskew_top.sv
test/deskew_tb.sv

// File: rtl/deskew_cfg_pkg.sv
`default_nettype none

package deskew_cfg_pkg;

    // Lane count and block width of the receive path
    localparam int N_LANES = 4;
    localparam int NB_DATA = 66;

    // All lanes side by side, lane 0 in the low slice
    localparam int NB_DATA_BUS = NB_DATA * N_LANES;

    // Entries per delay line
    localparam int FIFO_DEPTH = 16;

    // Largest accepted skew, in valid strobes
    localparam int MAX_SKEW = 8;

    // Width of the skew counters and of the programmed delays
    localparam int NB_DELAY_COUNT = $clog2(FIFO_DEPTH);

endpackage

`default_nettype wire

// File: rtl/deskew_ctrl_pkg.sv
`default_nettype none

package deskew_ctrl_pkg;

    // Deskew control phases
    typedef enum logic [2:0]
    {
        ST_IDLE       = 3'd0,
        // Enabled, no marker seen yet
        ST_WAIT_FIRST = 3'd1,
        // Lane counters running until every marker is in
        ST_COUNT      = 3'd2,
        // One cycle to load the delay lines
        ST_SET        = 3'd3,
        ST_ALIGNED    = 3'd4
    } deskew_state_t;

endpackage

`default_nettype wire

// File: rtl/deskew_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module deskew_fsm
(
    input wire                                          i_clock,
    input wire                                          i_rst_n,
    input wire                                          i_enable,
    input wire                                          i_valid,
    input wire                                          i_resync,
    input wire [deskew_cfg_pkg::N_LANES-1:0]            i_start_of_lane,
    input wire [deskew_cfg_pkg::NB_DELAY_COUNT-1:0]     i_common_count,
    output logic                                        o_enable_counters,
    output logic [deskew_cfg_pkg::N_LANES-1:0]          o_stop_lane_counters,
    output logic                                        o_set_fifo_delay,
    output logic                                        o_deskew_done
);

    import deskew_cfg_pkg::*;
    import deskew_ctrl_pkg::*;

    deskew_state_t          state_q;
    deskew_state_t          state_next;
    logic [N_LANES-1:0]     stop_q;
    logic [N_LANES-1:0]     stop_next;
    logic                   first_marker;
    logic                   skew_overrun;
    logic                   done_q;

    // Any marker on a valid strobe
    assign first_marker = i_valid && (|i_start_of_lane);

    // The common count equals the strobes seen since the first marker,
    // so one more strobe from here would exceed the limit
    assign skew_overrun = (i_common_count >= MAX_SKEW);

    always_comb
    begin
        state_next = state_q;
        stop_next  = stop_q;

        case (state_q)
            ST_IDLE:
            begin
                if (i_enable)
                begin
                    state_next = ST_WAIT_FIRST;
                end
            end

            ST_WAIT_FIRST:
            begin
                if (first_marker)
                begin
                    // Lanes marked on this strobe have skew 0
                    stop_next = i_start_of_lane;
                    if (&i_start_of_lane)
                    begin
                        state_next = ST_SET;
                    end
                    else
                    begin
                        state_next = ST_COUNT;
                    end
                end
            end

            ST_COUNT:
            begin
                if (i_valid)
                begin
                    // Repeated markers on stopped lanes change nothing
                    stop_next = stop_q | i_start_of_lane;
                    if (skew_overrun)
                    begin
                        state_next = ST_WAIT_FIRST;
                    end
                    else if (&stop_next)
                    begin
                        state_next = ST_SET;
                    end
                end
            end

            ST_SET:
            begin
                state_next = ST_ALIGNED;
            end

            ST_ALIGNED:
            begin
                state_next = ST_ALIGNED;
            end

            default:
            begin
                state_next = ST_IDLE;
            end
        endcase

        // Resync or disable overrides everything
        if (i_resync || !i_enable)
        begin
            state_next = ST_IDLE;
        end

        // Stop bits start fresh on every new measurement
        if ((state_next == ST_IDLE) || (state_next == ST_WAIT_FIRST))
        begin
            stop_next = '0;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (!i_rst_n)
        begin
            state_q <= ST_IDLE;
            stop_q  <= '0;
            done_q  <= 1'b0;
        end
        else
        begin
            state_q <= state_next;
            stop_q  <= stop_next;
            // Raised one cycle after the delays are loaded
            done_q  <= (state_q == ST_ALIGNED) && (state_next == ST_ALIGNED);
        end
    end

    // Counters stay enabled after the count so the delays see stable values
    assign o_enable_counters    = (state_q == ST_COUNT) ||
                                  (state_q == ST_SET) ||
                                  (state_q == ST_ALIGNED);
    assign o_stop_lane_counters = stop_q;
    assign o_set_fifo_delay     = (state_q == ST_SET);
    assign o_deskew_done        = done_q;

endmodule

`default_nettype wire

// File: rtl/deskew_top.sv
`timescale 1ns/100ps
`default_nettype none

module deskew_top
(
    input wire                                      i_clock,
    input wire                                      i_rst_n,
    input wire                                      i_enable,
    input wire                                      i_valid,
    input wire                                      i_resync,
    input wire [deskew_cfg_pkg::N_LANES-1:0]        i_start_of_lane,
    input wire [deskew_cfg_pkg::NB_DATA_BUS-1:0]    i_data,
    output logic [deskew_cfg_pkg::NB_DATA_BUS-1:0]  o_data,
    output logic                                    o_valid,
    output logic                                    o_deskew_done
);

    import deskew_cfg_pkg::*;

    logic                       enable_counters;
    logic [N_LANES-1:0]         stop_lane_counters;
    logic                       set_fifo_delay;
    logic [NB_DELAY_COUNT-1:0]  common_count;
    logic [NB_DELAY_COUNT-1:0]  lane_count [N_LANES];
    logic [NB_DATA_BUS-1:0]     delayed_data;

    deskew_fsm u_deskew_fsm
    (
        .i_clock                (i_clock),
        .i_rst_n                (i_rst_n),
        .i_enable               (i_enable),
        .i_valid                (i_valid),
        .i_resync               (i_resync),
        .i_start_of_lane        (i_start_of_lane),
        .i_common_count         (common_count),
        .o_enable_counters      (enable_counters),
        .o_stop_lane_counters   (stop_lane_counters),
        .o_set_fifo_delay       (set_fifo_delay),
        .o_deskew_done          (o_deskew_done)
    );

    // Runs until the last lane stops, ends at the largest skew
    skew_counter u_common_counter
    (
        .i_clock            (i_clock),
        .i_rst_n            (i_rst_n),
        .i_resync           (i_resync),
        .i_valid            (i_valid),
        .i_enable_counter   (enable_counters),
        .i_stop_counter     (&stop_lane_counters),
        .o_count            (common_count)
    );

    for (genvar lane = 0; lane < N_LANES; lane++)
    begin : g_lane
        skew_counter u_lane_counter
        (
            .i_clock            (i_clock),
            .i_rst_n            (i_rst_n),
            .i_resync           (i_resync),
            .i_valid            (i_valid),
            .i_enable_counter   (enable_counters),
            .i_stop_counter     (stop_lane_counters[lane]),
            .o_count            (lane_count[lane])
        );

        lane_delay_line u_lane_delay_line
        (
            .i_clock            (i_clock),
            .i_rst_n            (i_rst_n),
            .i_valid            (i_valid),
            .i_set_delay        (set_fifo_delay),
            .i_common_count     (common_count),
            .i_lane_count       (lane_count[lane]),
            .i_data             (i_data[lane*NB_DATA +: NB_DATA]),
            .o_data             (delayed_data[lane*NB_DATA +: NB_DATA])
        );
    end

    // Output stage, one clock after the strobe
    always_ff @(posedge i_clock)
    begin
        if (!i_rst_n)
        begin
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= i_valid;
        end
    end

    // Words only move on a strobe
    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            o_data <= delayed_data;
        end
    end

endmodule

`default_nettype wire

// File: rtl/lane_delay_line.sv
`timescale 1ns/100ps
`default_nettype none

module lane_delay_line
(
    input wire                                          i_clock,
    input wire                                          i_rst_n,
    input wire                                          i_valid,
    input wire                                          i_set_delay,
    input wire [deskew_cfg_pkg::NB_DELAY_COUNT-1:0]     i_common_count,
    input wire [deskew_cfg_pkg::NB_DELAY_COUNT-1:0]     i_lane_count,
    input wire [deskew_cfg_pkg::NB_DATA-1:0]            i_data,
    output logic [deskew_cfg_pkg::NB_DATA-1:0]          o_data
);

    import deskew_cfg_pkg::*;

    logic [NB_DATA-1:0]         mem [FIFO_DEPTH];
    logic [NB_DELAY_COUNT-1:0]  wr_ptr;
    logic [NB_DELAY_COUNT-1:0]  delay_q;
    logic [NB_DELAY_COUNT-1:0]  rd_addr;

    // Write side, one entry per strobe
    // Pointer width matches the depth, so it wraps on its own
    always_ff @(posedge i_clock)
    begin
        if (!i_rst_n)
        begin
            wr_ptr <= '0;
        end
        else if (i_valid)
        begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            mem[wr_ptr] <= i_data;
        end
    end

    // Early lanes wait for the latest one
    always_ff @(posedge i_clock)
    begin
        if (!i_rst_n)
        begin
            delay_q <= '0;
        end
        else if (i_set_delay)
        begin
            delay_q <= i_common_count - i_lane_count;
        end
    end

    // wr_ptr is the slot of the current word, so step back by the delay
    assign rd_addr = wr_ptr - delay_q;

    // Zero delay bypasses the buffer
    assign o_data = (delay_q == '0) ? i_data : mem[rd_addr];

endmodule

`default_nettype wire

// File: rtl/skew_counter.sv
`timescale 1ns/100ps
`default_nettype none

module skew_counter
(
    input wire                                          i_clock,
    input wire                                          i_rst_n,
    input wire                                          i_resync,
    input wire                                          i_valid,
    input wire                                          i_enable_counter,
    input wire                                          i_stop_counter,
    output logic [deskew_cfg_pkg::NB_DELAY_COUNT-1:0]   o_count
);

    logic count_full;

    // Saturate instead of wrapping
    assign count_full = &o_count;

    always_ff @(posedge i_clock)
    begin
        if (!i_rst_n)
        begin
            o_count <= '0;
        end
        else if (i_resync || !i_enable_counter)
        begin
            // Back to zero whenever the control machine is not counting
            o_count <= '0;
        end
        else if (i_valid && !i_stop_counter && !count_full)
        begin
            o_count <= o_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: test/deskew_model.svh
`ifndef DESKEW_MODEL_SVH
`define DESKEW_MODEL_SVH

// Marker position of each lane, in strobes after the first marker
int unsigned lane_skew [N_LANES];

// Delay each lane should carry once deskew is done
int unsigned lane_delay [N_LANES];

// Input bus of the most recent strobes, oldest first
logic [NB_DATA_BUS-1:0] bus_hist [$];

function automatic void clear_model();
    bus_hist.delete();
    for (int k = 0; k < N_LANES; k++)
    begin
        lane_skew[k]  = 0;
        lane_delay[k] = 0;
    end
endfunction

function automatic int unsigned largest_skew();
    int unsigned largest;
    largest = 0;
    for (int k = 0; k < N_LANES; k++)
    begin
        if (lane_skew[k] > largest)
        begin
            largest = lane_skew[k];
        end
    end
    return largest;
endfunction

// Early lanes wait for the latest marker
function automatic void compute_delays();
    int unsigned largest;
    largest = largest_skew();
    for (int k = 0; k < N_LANES; k++)
    begin
        lane_delay[k] = largest - lane_skew[k];
    end
endfunction

function automatic void record_strobe(input logic [NB_DATA_BUS-1:0] bus);
    bus_hist.push_back(bus);
    if (bus_hist.size() > FIFO_DEPTH)
    begin
        void'(bus_hist.pop_front());
    end
endfunction

// Lane k shows its word from lane_delay[k] strobes back
function automatic logic [NB_DATA_BUS-1:0] expected_bus();
    logic [NB_DATA_BUS-1:0] bus;
    int idx;
    bus = '0;
    for (int k = 0; k < N_LANES; k++)
    begin
        idx = bus_hist.size() - 1 - int'(lane_delay[k]);
        bus[k*NB_DATA +: NB_DATA] = bus_hist[idx][k*NB_DATA +: NB_DATA];
    end
    return bus;
endfunction

`endif

// File: test/deskew_tb.sv
`timescale 1ns/100ps
`default_nettype none

module deskew_tb;

    import deskew_cfg_pkg::*;
    import deskew_ctrl_pkg::*;

    localparam int CLK_PERIOD = 20;
    // Last marker sampled at E0, done raised at E0+2, seen before E0+3
    localparam int DONE_EDGES = 4;
    localparam int WAIT_LIMIT = 200;
    // Marker strobe just past the skew limit
    localparam int WITHHELD   = MAX_SKEW + 1;

    logic                   i_clock;
    logic                   i_rst_n;
    logic                   i_enable;
    logic                   i_valid;
    logic                   i_resync;
    logic [N_LANES-1:0]     i_start_of_lane;
    logic [NB_DATA_BUS-1:0] i_data;
    wire  [NB_DATA_BUS-1:0] o_data;
    wire                    o_valid;
    wire                    o_deskew_done;

    logic                   check_data_en;
    logic                   exp_valid;
    logic                   exp_check;
    logic [NB_DATA_BUS-1:0] exp_data;
    int                     mismatch_count = 0;
    int                     timeout_count = 0;

    `include "deskew_model.svh"

    deskew_top dut_i
    (
        .i_clock            (i_clock),
        .i_rst_n            (i_rst_n),
        .i_enable           (i_enable),
        .i_valid            (i_valid),
        .i_resync           (i_resync),
        .i_start_of_lane    (i_start_of_lane),
        .i_data             (i_data),
        .o_data             (o_data),
        .o_valid            (o_valid),
        .o_deskew_done      (o_deskew_done)
    );

    initial
    begin
        i_clock = 1'b0;
        forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
    end

    function automatic string phase_name(input deskew_state_t s);
        return s.name();
    endfunction

    function automatic logic [NB_DATA_BUS-1:0] random_bus();
        logic [NB_DATA_BUS-1:0] bus;
        bus = '0;
        for (int i = 0; i < (NB_DATA_BUS + 31) / 32; i++)
        begin
            bus = (bus << 32) | NB_DATA_BUS'($urandom);
        end
        return bus;
    endfunction

    // Roughly three strobes in four cycles
    function automatic logic random_valid();
        return ($urandom_range(3) != 0);
    endfunction

    function automatic void draw_skews();
        for (int k = 0; k < N_LANES; k++)
        begin
            lane_skew[k] = $urandom_range(MAX_SKEW);
        end
        lane_skew[$urandom_range(N_LANES - 1)] = 0;
    endfunction

    function automatic void report_data_mismatch();
        mismatch_count++;
        for (int k = 0; k < N_LANES; k++)
        begin
            if (o_data[k*NB_DATA +: NB_DATA] !== exp_data[k*NB_DATA +: NB_DATA])
            begin
                $display("MISMATCH at %0t: lane %0d word %h, expected %h (delay %0d)", $time,
                         k, o_data[k*NB_DATA +: NB_DATA], exp_data[k*NB_DATA +: NB_DATA],
                         lane_delay[k]);
            end
        end
    endfunction

    task automatic drive_cycle(input logic valid, input logic [N_LANES-1:0] markers);
        logic [NB_DATA_BUS-1:0] word;
        word = random_bus();
        @(posedge i_clock);
        i_valid         <= valid;
        i_start_of_lane <= valid ? markers : '0;
        i_data          <= word;
    endtask

    // Marker of lane k goes out on strobe lane_skew[k]
    task automatic run_round(input int unsigned last_strobe);
        int unsigned strobe;
        int cycles;
        logic valid;
        logic [N_LANES-1:0] markers;
        @(negedge i_clock);
        check_data_en = 1'b0;
        strobe = 0;
        cycles = 0;
        while ((strobe <= last_strobe) && (cycles < WAIT_LIMIT))
        begin
            valid = random_valid();
            markers = '0;
            if (valid)
            begin
                for (int k = 0; k < N_LANES; k++)
                begin
                    markers[k] = (lane_skew[k] == strobe);
                end
                strobe++;
            end
            drive_cycle(valid, markers);
            cycles++;
        end
        assert (strobe > last_strobe)
        else
        begin
            timeout_count++;
            $display("Timeout: the marker round never reached strobe %0d", last_strobe);
        end
    endtask

    task automatic complete_deskew();
        int cycles;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && (cycles < WAIT_LIMIT))
        begin
            drive_cycle(random_valid(), '0);
            cycles++;
            seen = o_deskew_done;
        end
        assert (seen)
        else
        begin
            timeout_count++;
            $display("Timeout: deskew did not complete after the last marker");
        end
        if (seen)
        begin
            assert (cycles == DONE_EDGES)
            else
            begin
                mismatch_count++;
                $display("MISMATCH at %0t: %s seen %0d edges after last marker, expected %0d",
                         $time, phase_name(ST_ALIGNED), cycles, DONE_EDGES);
            end
        end
        @(negedge i_clock);
        compute_delays();
        check_data_en = 1'b1;
    endtask

    task automatic run_aligned(input int n);
        for (int i = 0; i < n; i++)
        begin
            drive_cycle(random_valid(), '0);
            assert (o_deskew_done)
            else
            begin
                mismatch_count++;
                $display("MISMATCH at %0t: o_deskew_done low, expected phase %s", $time,
                         phase_name(ST_ALIGNED));
            end
        end
    endtask

    task automatic pulse_resync();
        drive_cycle(random_valid(), '0);
        i_resync <= 1'b1;
        drive_cycle(random_valid(), '0);
        i_resync <= 1'b0;
        drive_cycle(random_valid(), '0);
        assert (!o_deskew_done)
        else
        begin
            mismatch_count++;
            $display("MISMATCH at %0t: o_deskew_done high after resync, expected phase %s",
                     $time, phase_name(ST_IDLE));
        end
        drive_cycle(random_valid(), '0);
    endtask

    // Output checker, one strobe behind the input
    always @(posedge i_clock)
    begin
        if (!i_rst_n)
        begin
            exp_valid = 1'b0;
            exp_check = 1'b0;
        end
        else
        begin
            assert (o_valid === exp_valid)
            else
            begin
                mismatch_count++;
                $display("MISMATCH at %0t: o_valid %b, expected %b", $time, o_valid, exp_valid);
            end
            if (exp_valid && exp_check)
            begin
                assert (o_data === exp_data) else report_data_mismatch();
            end
            exp_valid = i_valid;
            exp_check = check_data_en;
            if (i_valid)
            begin
                record_strobe(i_data);
                exp_data = expected_bus();
            end
        end
    end

    initial
    begin
        int withheld;
        void'($urandom(32'h377d));
        i_rst_n = 1'b0;
        i_enable = 1'b0;
        i_valid = 1'b0;
        i_resync = 1'b0;
        i_start_of_lane = '0;
        i_data = '0;
        check_data_en = 1'b0;
        clear_model();
        repeat (3) @(posedge i_clock);
        i_rst_n <= 1'b1;
        i_enable <= 1'b1;
        drive_cycle(1'b0, '0);
        assert (!o_valid && !o_deskew_done)
        else
        begin
            mismatch_count++;
            $display("MISMATCH at %0t: outputs high after reset, expected phase %s", $time,
                     phase_name(ST_IDLE));
        end

        // Delays are 0 out of reset, output follows input
        @(negedge i_clock);
        check_data_en = 1'b1;
        repeat (24)
        begin
            drive_cycle(random_valid(), '0);
        end

        // All lanes marked on one strobe
        run_round(0);
        complete_deskew();
        run_aligned(30);

        for (int r = 0; r < 4; r++)
        begin
            pulse_resync();
            draw_skews();
            run_round(largest_skew());
            complete_deskew();
            run_aligned(40);
        end

        // One lane marked one strobe past the skew limit
        pulse_resync();
        draw_skews();
        withheld = $urandom_range(N_LANES - 1);
        lane_skew[withheld] = WITHHELD;
        lane_skew[(withheld + 1) % N_LANES] = 0;
        run_round(WITHHELD);
        for (int i = 0; i < 20; i++)
        begin
            drive_cycle(random_valid(), '0);
            assert (!o_deskew_done)
            else
            begin
                mismatch_count++;
                $display("MISMATCH at %0t: done with lane %0d past the skew limit, expected %s",
                         $time, withheld, phase_name(ST_WAIT_FIRST));
            end
        end
        draw_skews();
        run_round(largest_skew());
        complete_deskew();
        run_aligned(40);

        $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if ((mismatch_count == 0) && (timeout_count == 0))
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
